/* project.f */
+incdir+.
rs_branch_pkg.sv
rs_operand_capture.sv
rs_entry_queue.sv
rs_issue_reg.sv
rs_branch_top.sv
tb_rs_branch.sv

/* run_sim.sh */
#!/bin/sh
# build and run the branch reservation station testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_rs_branch \
    -o sim_rs_branch
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_rs_branch > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
echo "simulation passed"
exit 0

/* tb_rs_branch.sv */
`timescale 1ns/1ps
`include "rs_branch_consts.svh"

module tb_rs_branch;

    import rs_branch_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int RAND_CYCLES = 400;
    localparam int STIM_CYCLES = 600;    // all five tests with their drains
    localparam int CHK_W       = $bits(rs_entry_t);

    logic        clk = 1'b0;
    logic        reset;
    logic        flush;
    logic        dispatch_valid;
    logic        dispatch_ready;
    rs_entry_t   dispatch_entry;
    result_bus_t result_buses [`NUM_RESULT_BUSES];
    logic        issue_valid;
    logic        issue_ready;
    rs_entry_t   issue_entry;

    // reference model with the oldest in-flight instruction at the front
    rs_entry_t model_q [$];
    logic      model_issue_full = 1'b0;    // front entry sits in the issue register
    logic      prev_stall = 1'b0;
    rs_entry_t prev_entry;
    logic      saw_full = 1'b0;
    int        issued_total = 0;
    inst_num_t inst_seq = '0;
    string     current_test = "reset";

    rs_branch_top UUT (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_entry (dispatch_entry),
        .result_buses   (result_buses),
        .issue_valid    (issue_valid),
        .issue_ready    (issue_ready),
        .issue_entry    (issue_entry)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // capture and wakeup rule where the first valid lane with the tag wins
    function automatic rs_entry_t resolve_operands(input rs_entry_t e,
                                                   input result_bus_t lanes [`NUM_RESULT_BUSES]);
        rs_entry_t r;
        logic      got1;
        logic      got2;
        r    = e;
        got1 = e.src1.ready;
        got2 = e.src2.ready;
        for (int lane = 0; lane < `NUM_RESULT_BUSES; lane++) begin
            if (lanes[lane].valid && !got1 && lanes[lane].tag == e.src1.tag) begin
                r.src1.data  = lanes[lane].data;
                r.src1.ready = 1'b1;
                got1         = 1'b1;
            end
            if (lanes[lane].valid && !got2 && lanes[lane].tag == e.src2.tag) begin
                r.src2.data  = lanes[lane].data;
                r.src2.ready = 1'b1;
                got2         = 1'b1;
            end
        end
        return r;
    endfunction

    function automatic rs_entry_t make_entry(input logic rdy1, input phys_tag_t tag1,
                                             input logic rdy2, input phys_tag_t tag2);
        rs_entry_t e;
        e.info.inst_num   = inst_seq;
        e.info.pc         = word_t'($urandom) & ~word_t'(3);
        e.info.rd         = phys_tag_t'($urandom);
        e.info.is_jump    = ($urandom % 4) == 0;
        e.info.is_branch  = !e.info.is_jump;
        e.info.funct3     = funct3_t'($urandom % 8);
        e.info.imm        = word_t'($urandom);
        e.info.pred_taken = ($urandom % 2) == 0;
        e.info.pred_hit   = ($urandom % 2) == 0;
        e.src1.tag        = tag1;
        e.src1.data       = word_t'($urandom);   // junk unless ready
        e.src1.ready      = rdy1;
        e.src2.tag        = tag2;
        e.src2.data       = word_t'($urandom);
        e.src2.ready      = rdy2;
        inst_seq          = inst_seq + 1'b1;
        return e;
    endfunction

    function automatic phys_tag_t pool_tag();
        return phys_tag_t'(8'h10 + ($urandom % 16));    // small pool so wakeups hit
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [CHK_W-1:0] expected,
                               input logic [CHK_W-1:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("error %s %s: expected %h, actual %h",
                                current_test, what, expected, actual));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic clear_buses();
        for (int lane = 0; lane < `NUM_RESULT_BUSES; lane++) begin
            result_buses[lane] = '0;
        end
    endtask

    task automatic drive_lane(input int lane, input phys_tag_t tag, input word_t data);
        result_buses[lane].valid = 1'b1;
        result_buses[lane].tag   = tag;
        result_buses[lane].data  = data;
    endtask

    // hold valid until the queue takes it
    task automatic dispatch_one(input rs_entry_t e);
        logic taken;
        dispatch_valid = 1'b1;
        dispatch_entry = e;
        taken          = 1'b0;
        while (!taken) begin
            taken = dispatch_ready;
            next_cycle();
        end
        dispatch_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (model_q.size() != 0) begin
            next_cycle();
        end
    endtask

    // model update sampled mid-cycle for the coming rising edge
    always @(negedge clk) begin
        rs_entry_t front;
        logic      can_load;
        if (reset) begin
            model_q.delete();
            model_issue_full = 1'b0;
            prev_stall       = 1'b0;
        end else begin
            check_value("issue_valid", CHK_W'(model_issue_full), CHK_W'(issue_valid));
            if (model_q.size() > `RS_DEPTH) begin
                check_value("dispatch_ready when full", CHK_W'(0), CHK_W'(dispatch_ready));
                saw_full = 1'b1;
            end else if (model_q.size() < `RS_DEPTH) begin
                check_value("dispatch_ready", CHK_W'(1), CHK_W'(dispatch_ready));
            end
            if (prev_stall) begin
                check_value("entry held under stall", prev_entry, issue_entry);
            end
            can_load = !model_issue_full || issue_ready;
            if (issue_valid && issue_ready) begin
                if (model_q.size() == 0) begin
                    abort_run("an instruction issued that was never dispatched");
                end
                front = model_q.pop_front();
                check_value("issued entry", front, issue_entry);
                issued_total++;
            end
            if (flush) begin
                model_q.delete();
                model_issue_full = 1'b0;
            end else begin
                if (can_load) begin
                    model_issue_full = model_q.size() != 0
                                       && model_q[0].src1.ready && model_q[0].src2.ready;
                end
                for (int i = 0; i < model_q.size(); i++) begin
                    model_q[i] = resolve_operands(model_q[i], result_buses);
                end
                if (dispatch_valid && dispatch_ready) begin
                    model_q.push_back(resolve_operands(dispatch_entry, result_buses));
                end
            end
            prev_stall = issue_valid && !issue_ready && !flush;
            prev_entry = issue_entry;
        end
    end

    // limit from the stimulus length with a margin of four
    initial begin
        #(STIM_CYCLES * CLK_PERIOD * 4);
        if (model_q.size() != 0) begin
            abort_run("an accepted instruction never issued before the time limit");
        end else begin
            abort_run("watchdog expired, the tests did not finish in time");
        end
    end

    task automatic issue_in_order();
        current_test = "in_order";
        issue_ready  = 1'b1;
        for (int n = 0; n < 20; n++) begin
            dispatch_one(make_entry(1'b1, phys_tag_t'($urandom), 1'b1, phys_tag_t'($urandom)));
        end
        wait_drain();
    endtask

    task automatic block_on_wakeup();
        current_test = "wakeup";
        issue_ready  = 1'b1;
        dispatch_one(make_entry(1'b0, 8'h41, 1'b1, 8'h07));    // waits on tag A
        dispatch_one(make_entry(1'b1, 8'h42, 1'b1, 8'h43));    // ready but behind it
        repeat (6) next_cycle();
        drive_lane(2, 8'h41, 32'hc0de_0a1e);
        next_cycle();
        clear_buses();
        wait_drain();
    endtask

    task automatic capture_at_dispatch();
        current_test = "capture";
        issue_ready  = 1'b1;
        drive_lane(0, 8'h51, 32'h1111_0051);
        dispatch_one(make_entry(1'b0, 8'h51, 1'b1, 8'h01));
        clear_buses();
        drive_lane(3, 8'h52, 32'h3333_0052);
        dispatch_one(make_entry(1'b1, 8'h02, 1'b0, 8'h52));
        clear_buses();
        drive_lane(1, 8'h53, 32'h1111_0053);       // both operands bypass
        drive_lane(4, 8'h54, 32'h4444_0054);
        dispatch_one(make_entry(1'b0, 8'h53, 1'b0, 8'h54));
        clear_buses();
        drive_lane(1, 8'h55, 32'h1111_0055);       // same tag twice so lane 1 wins
        drive_lane(3, 8'h55, 32'h3333_0055);
        dispatch_one(make_entry(1'b0, 8'h55, 1'b0, 8'h55));
        clear_buses();
        drive_lane(0, 8'h56, 32'hbad0_0056);       // register file value must stay
        dispatch_one(make_entry(1'b1, 8'h56, 1'b1, 8'h03));
        clear_buses();
        result_buses[2].tag  = 8'h58;              // idle lane gets no compare
        result_buses[2].data = 32'hdead_0058;
        dispatch_one(make_entry(1'b0, 8'h58, 1'b1, 8'h04));
        clear_buses();
        drive_lane(4, 8'h58, 32'h4444_0058);
        next_cycle();
        clear_buses();
        wait_drain();
    endtask

    task automatic stress_backpressure();
        int start;
        int k;
        current_test = "backpressure";
        start        = issued_total;
        saw_full     = 1'b0;
        for (int cyc = 0; cyc < RAND_CYCLES; cyc++) begin
            dispatch_valid = ($urandom % 10) < 7;
            dispatch_entry = make_entry(($urandom % 2) == 0, pool_tag(),
                                        ($urandom % 2) == 0, pool_tag());
            // mostly stalled first and mostly draining later
            if (cyc < RAND_CYCLES / 2) begin
                issue_ready = ($urandom % 4) == 0;
            end else begin
                issue_ready = ($urandom % 4) != 0;
            end
            for (int lane = 0; lane < `NUM_RESULT_BUSES; lane++) begin
                result_buses[lane].valid = ($urandom % 4) == 0;
                result_buses[lane].tag   = pool_tag();
                result_buses[lane].data  = word_t'($urandom);
            end
            next_cycle();
        end
        dispatch_valid = 1'b0;
        issue_ready    = 1'b1;
        k              = 0;
        while (model_q.size() != 0) begin
            clear_buses();
            drive_lane(0, phys_tag_t'(8'h10 + k % 16), word_t'($urandom));   // sweep the pool
            k++;
            next_cycle();
        end
        clear_buses();
        check_value("queue reached full", CHK_W'(1), CHK_W'(saw_full));
        if (issued_total == start) begin
            abort_run("nothing issued during the random back-pressure run");
        end
    endtask

    task automatic flush_midstream();
        current_test = "flush";
        issue_ready  = 1'b0;
        for (int n = 0; n < 5; n++) begin
            dispatch_one(make_entry(1'b1, 8'h61, 1'b1, 8'h62));
        end
        while (!issue_valid) begin
            next_cycle();
        end
        flush          = 1'b1;
        dispatch_valid = 1'b1;                      // dropped since flush wins
        dispatch_entry = make_entry(1'b1, 8'h63, 1'b1, 8'h64);
        next_cycle();
        flush          = 1'b0;
        dispatch_valid = 1'b0;
        check_value("issue_valid after flush", CHK_W'(0), CHK_W'(issue_valid));
        check_value("dispatch_ready after flush", CHK_W'(1), CHK_W'(dispatch_ready));
        issue_ready = 1'b1;
        repeat (4) next_cycle();
        for (int n = 0; n < 4; n++) begin
            dispatch_one(make_entry(1'b1, 8'h65, 1'b1, 8'h66));
        end
        wait_drain();
    endtask

    initial begin
        void'($urandom(32'hbffb75ed));
        reset          = 1'b1;
        flush          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_entry = '0;
        issue_ready    = 1'b0;
        clear_buses();
        next_cycle();
        next_cycle();
        reset = 1'b0;
        issue_in_order();
        block_on_wakeup();
        capture_at_dispatch();
        stress_backpressure();
        flush_midstream();
        next_cycle();
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* rs_branch_top.sv */
`timescale 1ns/1ps
`include "rs_branch_consts.svh"

module rs_branch_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flush,
    input  logic                       dispatch_valid,
    output logic                       dispatch_ready,
    input  rs_branch_pkg::rs_entry_t   dispatch_entry,
    input  rs_branch_pkg::result_bus_t result_buses [`NUM_RESULT_BUSES],
    output logic                       issue_valid,
    input  logic                       issue_ready,
    output rs_branch_pkg::rs_entry_t   issue_entry
);

    import rs_branch_pkg::*;

    rs_entry_t captured_entry;    // dispatch entry after same-cycle forwarding
    rs_entry_t head_entry;
    logic      head_valid;
    logic      head_pop;

    rs_operand_capture u_capture (
        .result_buses   (result_buses),
        .dispatch_entry (dispatch_entry),
        .captured_entry (captured_entry)
    );

    // in-order store with broadcast wakeup
    rs_entry_queue u_queue (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .push_valid   (dispatch_valid),
        .push_ready   (dispatch_ready),
        .push_entry   (captured_entry),
        .result_buses (result_buses),
        .head_valid   (head_valid),
        .head_entry   (head_entry),
        .head_pop     (head_pop)
    );

    rs_issue_reg u_issue (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .head_valid  (head_valid),
        .head_entry  (head_entry),
        .head_pop    (head_pop),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_entry (issue_entry)
    );

endmodule

/* rs_issue_reg.sv */
`timescale 1ns/1ps
`include "rs_branch_consts.svh"

module rs_issue_reg (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     flush,
    input  logic                     head_valid,
    input  rs_branch_pkg::rs_entry_t head_entry,
    output logic                     head_pop,
    output logic                     issue_valid,
    input  logic                     issue_ready,
    output rs_branch_pkg::rs_entry_t issue_entry
);

    import rs_branch_pkg::*;

    rs_entry_t entry_q;    // payload held toward the branch unit
    logic      can_load;

    // free when empty or when the branch unit drains it this cycle
    assign can_load = !issue_valid || issue_ready;
    assign head_pop = head_valid && can_load;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            issue_valid <= 1'b0;
        end else if (can_load) begin
            issue_valid <= head_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (head_pop) begin
            entry_q <= head_entry;
        end
    end

    assign issue_entry = entry_q;

    // a stalled output keeps both valid and payload until accepted
    a_hold_under_stall: assert property (
        @(posedge clk) disable iff (reset)
        (issue_valid && !issue_ready && !flush) |=> (issue_valid && $stable(issue_entry))
    ) else $error("issue output changed while stalled");

endmodule

/* rs_entry_queue.sv */
`timescale 1ns/1ps
`include "rs_branch_consts.svh"

module rs_entry_queue (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flush,
    input  logic                       push_valid,
    output logic                       push_ready,
    input  rs_branch_pkg::rs_entry_t   push_entry,
    input  rs_branch_pkg::result_bus_t result_buses [`NUM_RESULT_BUSES],
    output logic                       head_valid,
    output rs_branch_pkg::rs_entry_t   head_entry,
    input  logic                       head_pop
);

    import rs_branch_pkg::*;

    rs_entry_t entries [`RS_DEPTH];    // entry storage
    rs_entry_t woken   [`RS_DEPTH];    // storage after this cycle's broadcasts
    rs_ptr_t   head_ptr;
    rs_ptr_t   tail_ptr;
    rs_count_t count;
    logic      full;
    logic      empty;
    logic      do_push;

    // advance with wrap at RS_DEPTH, depth need not be a power of two
    function automatic rs_ptr_t ptr_next(input rs_ptr_t ptr);
        rs_ptr_t nxt;
        if (ptr == rs_ptr_t'(`RS_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign full       = (count == rs_count_t'(`RS_DEPTH));
    assign empty      = (count == '0);
    assign push_ready = !full;
    assign do_push    = push_valid && push_ready;

    assign head_entry = entries[head_ptr];
    // strict in-order issue, a waiting head blocks everything behind it
    assign head_valid = !empty && head_entry.src1.ready && head_entry.src2.ready;

    // broadcast wakeup
    // every waiting operand is compared against all valid lanes,
    // lane 0 has the highest priority
    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            woken[i] = entries[i];
            for (int lane = `NUM_RESULT_BUSES - 1; lane >= 0; lane--) begin
                if (result_buses[lane].valid) begin
                    if (!entries[i].src1.ready
                        && (entries[i].src1.tag == result_buses[lane].tag)) begin
                        woken[i].src1.data  = result_buses[lane].data;
                        woken[i].src1.ready = 1'b1;
                    end
                    if (!entries[i].src2.ready
                        && (entries[i].src2.tag == result_buses[lane].tag)) begin
                        woken[i].src2.data  = result_buses[lane].data;
                        woken[i].src2.ready = 1'b1;
                    end
                end
            end
        end
    end

    // storage, free slots may pick up stale wakeups but are never read
    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            entries[i] <= woken[i];
        end
        if (do_push) begin
            entries[tail_ptr] <= push_entry;   // capture already resolved it
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (do_push) begin
                tail_ptr <= ptr_next(tail_ptr);
            end
            if (head_pop) begin
                head_ptr <= ptr_next(head_ptr);
            end
            case ({do_push, head_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // both or neither
            endcase
        end
    end

    // the issue register may only take a head that is ready
    a_pop_needs_valid: assert property (
        @(posedge clk) disable iff (reset)
        head_pop |-> head_valid
    ) else $error("head popped while not valid");

    a_count_bound: assert property (
        @(posedge clk) disable iff (reset)
        count <= rs_count_t'(`RS_DEPTH)
    ) else $error("occupancy above depth");

    // filling the last slot must close the dispatch side on the next cycle
    a_full_closes_push: assert property (
        @(posedge clk) disable iff (reset)
        (count == rs_count_t'(`RS_DEPTH - 1) && do_push && !head_pop && !flush)
            |=> !push_ready
    ) else $error("push_ready high with queue full");

endmodule

/* rs_operand_capture.sv */
`timescale 1ns/1ps
`include "rs_branch_consts.svh"

module rs_operand_capture (
    input  rs_branch_pkg::result_bus_t result_buses [`NUM_RESULT_BUSES],
    input  rs_branch_pkg::rs_entry_t   dispatch_entry,
    output rs_branch_pkg::rs_entry_t   captured_entry
);

    import rs_branch_pkg::*;

    logic [`NUM_RESULT_BUSES-1:0] src1_match;   // lanes carrying src1's tag
    logic [`NUM_RESULT_BUSES-1:0] src2_match;
    src_operand_t                 src1_res;
    src_operand_t                 src2_res;

    // tags are only compared on lanes that are valid this cycle
    always_comb begin
        for (int lane = 0; lane < `NUM_RESULT_BUSES; lane++) begin
            src1_match[lane] = result_buses[lane].valid
                               && (result_buses[lane].tag == dispatch_entry.src1.tag);
            src2_match[lane] = result_buses[lane].valid
                               && (result_buses[lane].tag == dispatch_entry.src2.tag);
        end
    end

    // walk the lanes downward so the lowest matching lane is written last
    always_comb begin
        src1_res = dispatch_entry.src1;
        src2_res = dispatch_entry.src2;
        for (int lane = `NUM_RESULT_BUSES - 1; lane >= 0; lane--) begin
            if (src1_match[lane] && !dispatch_entry.src1.ready) begin
                src1_res.data  = result_buses[lane].data;
                src1_res.ready = 1'b1;
            end
            if (src2_match[lane] && !dispatch_entry.src2.ready) begin
                src2_res.data  = result_buses[lane].data;
                src2_res.ready = 1'b1;
            end
        end
    end

    // an operand already ready from the register file keeps its value
    assign captured_entry.info = dispatch_entry.info;   // payload untouched
    assign captured_entry.src1 = src1_res;
    assign captured_entry.src2 = src2_res;

endmodule

/* rs_branch_pkg.sv */
`include "rs_branch_consts.svh"

package rs_branch_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`PHYS_TAG_W-1:0] phys_tag_t;
    typedef logic [`INST_NUM_W-1:0] inst_num_t;
    typedef logic [`FUNCT3_W-1:0]   funct3_t;
    typedef logic [`RS_PTR_W-1:0]   rs_ptr_t;
    typedef logic [`RS_CNT_W-1:0]   rs_count_t;   // occupancy, 0 to RS_DEPTH

    // one broadcast lane, live for a single cycle
    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
        word_t     data;
    } result_bus_t;

    // ready means data holds the final operand value
    typedef struct packed {
        phys_tag_t tag;
        word_t     data;
        logic      ready;
    } src_operand_t;

    typedef struct packed {
        inst_num_t inst_num;
        word_t     pc;
        phys_tag_t rd;
        logic      is_jump;
        logic      is_branch;
        funct3_t   funct3;
        word_t     imm;
        logic      pred_taken;   // predictor direction
        logic      pred_hit;     // btb hit
    } branch_info_t;

    // queue slot and issue payload share this layout
    typedef struct packed {
        branch_info_t info;
        src_operand_t src1;
        src_operand_t src2;
    } rs_entry_t;

endpackage

/* rs_branch_consts.svh */
`ifndef RS_BRANCH_CONSTS_SVH
`define RS_BRANCH_CONSTS_SVH

// queue geometry
`define RS_DEPTH 16
`define RS_PTR_W 4            // log2 of RS_DEPTH

// occupancy needs one more bit than a pointer to reach RS_DEPTH
`define RS_CNT_W (`RS_PTR_W + 1)

// datapath widths
`define XLEN 32               // data, pc and immediate
`define PHYS_TAG_W 8          // physical register tag
`define INST_NUM_W 32         // sequence number from dispatch
`define FUNCT3_W 3            // branch condition code

// alu, mul, div, load, branch return
`define NUM_RESULT_BUSES 5

`endif
